//--- common/ps2_pkg.sv
// ----------------------------------------
// PS/2 line protocol definitions for the mouse host
// frame layout, packet layout and the command byte it sends
// ----------------------------------------
package ps2_pkg;

  // one byte on the line is start, eight data bits, odd parity and stop
  localparam int frame_bits = 11;

  // a mouse report is three frames sent back to back
  localparam int packet_bits = 3 * frame_bits;

  // eleven command clocks (ack included) plus the eleven bits of the FA answer
  localparam int response_bits = 22;

  // command byte that switches the mouse to streaming mode
  localparam logic [7:0] cmd_stream_enable = 8'hF4;

  // the line sends the start bit first, so it sits in the lowest bit
  typedef struct packed {
    logic       stop;
    logic       parity;
    logic [7:0] data;
    logic       start;
  } frame_t;

  // field view of one report, flags frame lowest since it arrives first
  typedef struct packed {
    logic       y_stop;
    logic       y_parity;
    logic [7:0] y_data;
    logic       y_start;
    logic       x_stop;
    logic       x_parity;
    logic [7:0] x_data;
    logic       x_start;
    logic       f_stop;
    logic       f_parity;
    logic       y_overflow;
    logic       x_overflow;
    logic       y_sign;
    logic       x_sign;
    logic       always_one;
    logic       middle;
    logic       right;
    logic       left;
    logic       f_start;
  } report_t;

  // the same 33 bits seen as line frames or as report fields
  typedef union packed {
    frame_t [2:0] frames;
    report_t      report;
  } packet_u;

endpackage

//--- common/mouse_pkg.sv
// ----------------------------------------
// cursor types and the start position of the absolute pointer
// ----------------------------------------
package mouse_pkg;

  // absolute cursor coordinate, wide enough for common video modes
  typedef logic [11:0] coord_t;

  // one report increment as sign flag above the eight data bits
  typedef logic signed [8:0] incr_t;

  // the cursor starts near the middle of a 1024 by 768 screen
  localparam coord_t reset_x = 12'd500;
  localparam coord_t reset_y = 12'd340;

endpackage

//--- ps2/ps2_clk_tracker.sv
// ----------------------------------------
// follows the mouse clock line and turns each settled edge into a pulse
// the rest of the host works from these pulses only
// ----------------------------------------
`timescale 1ns/100ps

module ps2_clk_tracker #(
  parameter int debounce_value = 246,
  parameter int debounce_bits  = 8
) (
  input  logic clk,
  input  logic reset,
  input  logic ps2_clk,
  output logic clean_clk,
  output logic clk_rise,
  output logic clk_fall
);

  // edge machine encoding
  localparam logic [2:0] st_clk_h      = 3'd0;
  localparam logic [2:0] st_fall_edge  = 3'd1;
  localparam logic [2:0] st_fall_wait  = 3'd3;
  localparam logic [2:0] st_clk_l      = 3'd2;
  localparam logic [2:0] st_rise_edge  = 3'd6;
  localparam logic [2:0] st_rise_wait  = 3'd4;

  logic                     sync_q1;
  logic                     sync_q2;
  logic [2:0]               state;
  logic [2:0]               next_state;
  logic [debounce_bits-1:0] debounce_count;
  logic                     debounce_done;

  // two flops against metastability, the idle line is high
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      sync_q1 <= 1'b1;
      sync_q2 <= 1'b1;
    end
    else
    begin
      sync_q1 <= ps2_clk;
      sync_q2 <= sync_q1;
    end
  end

  // restarts on every pulse and stops once the settle time is reached
  always_ff @(posedge clk)
  begin
    if (reset || clk_rise || clk_fall)
      debounce_count <= '0;
    else if (!debounce_done)
      debounce_count <= debounce_count + 1'b1;
  end

  assign debounce_done = (debounce_count == debounce_bits'(debounce_value - 1));

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= st_clk_h;
    else
      state <= next_state;
  end

  // a line change reaches sync_q2 after two cycles and the edge state after three
  always_comb
  begin
    next_state = state;
    case (state)
      st_clk_h:
        if (!sync_q2)
          next_state = st_fall_edge;
      st_fall_edge:
        next_state = st_fall_wait;
      // bounces on the line are ignored until the timer runs out
      st_fall_wait:
        if (debounce_done)
          next_state = st_clk_l;
      st_clk_l:
        if (sync_q2)
          next_state = st_rise_edge;
      st_rise_edge:
        next_state = st_rise_wait;
      st_rise_wait:
        if (debounce_done)
          next_state = st_clk_h;
      default:
        next_state = st_clk_h;
    endcase
  end

  // each edge state lasts exactly one cycle, so the pulses do too
  assign clk_fall  = (state == st_fall_edge);
  assign clk_rise  = (state == st_rise_edge);
  assign clean_clk = (state == st_clk_h) || (state == st_rise_edge) ||
                     (state == st_rise_wait);

endmodule

//--- ps2/ps2_receiver.sv
// ----------------------------------------
// shifts in mouse bits on falling clock edges and checks whole packets
// a watchdog clears the bit count once the line has gone quiet
// ----------------------------------------
`timescale 1ns/100ps

module ps2_receiver #(
  parameter int watchdog_value = 26000,
  parameter int watchdog_bits  = 15
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             ps2_data,
  input  logic             clk_rise,
  input  logic             clk_fall,
  output logic [5:0]       bit_count,
  output logic             watchdog_done,
  output ps2_pkg::packet_u packet,
  output logic             packet_good
);

  localparam int num_frames = ps2_pkg::packet_bits / ps2_pkg::frame_bits;

  logic [ps2_pkg::packet_bits-1:0] shift_q;
  logic [watchdog_bits-1:0]        watchdog_count;

  // ----------------------------------------
  // bit counter and shift register
  // ----------------------------------------

  // the watchdog clear repairs any count left wrong by a lost or extra edge
  always_ff @(posedge clk)
  begin
    if (reset)
      bit_count <= '0;
    else if (clk_fall)
      bit_count <= bit_count + 6'd1;
    else if (watchdog_done)
      bit_count <= '0;
  end

  // the mouse holds data steady while the clock is low
  // so sampling in the pulse three cycles after the fall is safe
  // LSB first, so each new bit enters at the top and moves down
  always_ff @(posedge clk)
  begin
    if (clk_fall)
      shift_q <= {ps2_data, shift_q[ps2_pkg::packet_bits-1:1]};
  end

  assign packet = shift_q;

  // ----------------------------------------
  // watchdog
  // ----------------------------------------

  // counts from the last edge of either kind and parks at the limit
  always_ff @(posedge clk)
  begin
    if (reset || clk_rise || clk_fall)
      watchdog_count <= '0;
    else if (!watchdog_done)
      watchdog_count <= watchdog_count + 1'b1;
  end

  // stays high from expiry until the next edge restarts the count
  assign watchdog_done = (watchdog_count == watchdog_bits'(watchdog_value - 1));

  // ----------------------------------------
  // packet check
  // ----------------------------------------

  // every frame needs start low, stop high and an odd count of ones over data and parity
  always_comb
  begin
    packet_good = 1'b1;
    for (int i = 0; i < num_frames; i++)
    begin
      if (packet.frames[i].start || !packet.frames[i].stop ||
          (packet.frames[i].parity == ^packet.frames[i].data))
        packet_good = 1'b0;
    end
  end

endmodule

//--- ps2/ps2_link_control.sv
// ----------------------------------------
// host state machine for the PS/2 link
// enables streaming after reset or a broken packet and gathers reports
// ----------------------------------------
`timescale 1ns/100ps

module ps2_link_control (
  input  logic       clk,
  input  logic       reset,
  inout  wire        ps2_clk,
  inout  wire        ps2_data,
  input  logic       clean_clk,
  input  logic       clk_rise,
  input  logic       clk_fall,
  input  logic [5:0] bit_count,
  input  logic       watchdog_done,
  input  logic       packet_good,
  output logic       packet_strobe,
  output logic       error_no_ack
);

  localparam logic [3:0] st_reset        = 4'd14;
  localparam logic [3:0] st_wait         = 4'd0;
  localparam logic [3:0] st_gather       = 4'd1;
  localparam logic [3:0] st_verify       = 4'd3;
  localparam logic [3:0] st_use          = 4'd2;
  localparam logic [3:0] st_hold_clk_l   = 4'd6;
  localparam logic [3:0] st_data_low_1   = 4'd4;
  localparam logic [3:0] st_data_high_1  = 4'd5;
  localparam logic [3:0] st_data_low_2   = 4'd7;
  localparam logic [3:0] st_data_high_2  = 4'd8;
  localparam logic [3:0] st_data_low_3   = 4'd9;
  localparam logic [3:0] st_data_high_3  = 4'd11;
  localparam logic [3:0] st_error_no_ack = 4'd15;
  localparam logic [3:0] st_await_resp   = 4'd10;

  localparam logic [5:0] full_count = 6'(ps2_pkg::packet_bits);
  localparam logic [5:0] resp_count = 6'(ps2_pkg::response_bits);

  logic [3:0] state;
  logic [3:0] next_state;
  logic       clk_drive_low;
  logic       data_drive_low;

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= st_reset;
    else
      state <= next_state;
  end

  always_comb
  begin
    next_state = state;
    case (state)
      // one idle cycle after reset, then the command is started
      st_reset:
        next_state = st_hold_clk_l;
      st_wait:
        if (clk_fall)
          next_state = st_gather;
      // a quiet line ends the packet, a short one means the mouse lost sync
      st_gather:
        if (watchdog_done && (bit_count == full_count))
          next_state = st_verify;
        else if (watchdog_done && (bit_count < full_count))
          next_state = st_hold_clk_l;
      st_verify:
        if (packet_good)
          next_state = st_use;
        else
          next_state = st_wait;
      st_use:
        next_state = st_wait;

      // ----------------------------------------
      // F4 command send
      // ----------------------------------------

      // holding the clock low makes a falling edge that restarts the watchdog
      // so the hold lasts one watchdog period
      // in the edge cycle itself the old expiry is still visible and is ignored
      st_hold_clk_l:
        if (watchdog_done && !clean_clk && !clk_fall)
          next_state = st_data_low_1;
      // clock released with data low is the start bit
      // the mouse then clocks d0 to d7, parity, stop and its ack
      // it reads each bit while the clock is low and the host changes data on the rise
      // the count is zero here since the watchdog cleared it during the hold
      st_data_low_1:
        if (clk_rise && (bit_count == 6'd2))
          next_state = st_data_high_1;
      // d2 is one
      st_data_high_1:
        if (clk_rise && (bit_count == 6'd3))
          next_state = st_data_low_2;
      // d3 is zero
      st_data_low_2:
        if (clk_rise && (bit_count == 6'd4))
          next_state = st_data_high_2;
      // d4 to d7 are ones
      st_data_high_2:
        if (clk_rise && (bit_count == 6'd8))
          next_state = st_data_low_3;
      // F4 has five ones so the odd parity bit is zero
      st_data_low_3:
        if (clk_rise && (bit_count == 6'd9))
          next_state = st_data_high_3;
      // data released for the stop bit
      // the mouse must hold data low through the low phase of the eleventh clock
      st_data_high_3:
        if (clk_fall && (bit_count == 6'd10))
        begin
          if (ps2_data)
            next_state = st_error_no_ack;
          else
            next_state = st_await_resp;
        end
      // only a reset leaves the error state
      st_error_no_ack:
        next_state = st_error_no_ack;
      // the FA answer must start before the watchdog clears the count
      // verify then fails on the ack bit sitting in a stop position
      st_await_resp:
        if (bit_count == resp_count)
          next_state = st_verify;
      default:
        next_state = st_wait;
    endcase
  end

  // the lines are only ever pulled low, the pullups supply the high level
  assign clk_drive_low  = (state == st_hold_clk_l);
  assign data_drive_low = (state == st_data_low_1) || (state == st_data_low_2) ||
                          (state == st_data_low_3);

  assign ps2_clk  = clk_drive_low  ? 1'b0 : 1'bz;
  assign ps2_data = data_drive_low ? 1'b0 : 1'bz;

  assign packet_strobe = (state == st_use);
  assign error_no_ack  = (state == st_error_no_ack);

endmodule

//--- logic/mouse_tracker.sv
// ----------------------------------------
// holds the last good report and moves the absolute cursor
// Y runs downward as on a video screen
// ----------------------------------------
`timescale 1ns/100ps

module mouse_tracker #(
  parameter int max_x = 1023,
  parameter int max_y = 767
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              packet_strobe,
  input  ps2_pkg::packet_u  packet,
  output mouse_pkg::coord_t mx,
  output mouse_pkg::coord_t my,
  output mouse_pkg::incr_t  dx,
  output mouse_pkg::incr_t  dy,
  output logic              btn_left,
  output logic              btn_right,
  output logic              mouse_valid
);

  localparam mouse_pkg::coord_t limit_x = mouse_pkg::coord_t'(max_x);
  localparam mouse_pkg::coord_t limit_y = mouse_pkg::coord_t'(max_y);

  logic [8:0] mag_x;
  logic [8:0] mag_y;

  // size of a move, a negative zero byte means 256
  function automatic logic [8:0] magnitude(input logic sign, input logic [7:0] data);
    return sign ? ({1'b0, ~data} + 9'd1) : {1'b0, data};
  endfunction

  // one step of the cursor, clamped to zero below and the limit above
  function automatic mouse_pkg::coord_t step(input mouse_pkg::coord_t pos,
                                             input logic [8:0]        mag,
                                             input logic              up,
                                             input mouse_pkg::coord_t limit);
    logic [12:0] sum;
    sum = {1'b0, pos} + {4'd0, mag};
    if (up)
      return (sum > {1'b0, limit}) ? limit : sum[11:0];
    return (pos > {3'd0, mag}) ? (pos - {3'd0, mag}) : '0;
  endfunction

  assign mag_x = magnitude(packet.report.x_sign, packet.report.x_data);
  assign mag_y = magnitude(packet.report.y_sign, packet.report.y_data);

  // the packet is only valid during the strobe, so everything is taken then
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      mx          <= mouse_pkg::reset_x;
      my          <= mouse_pkg::reset_y;
      dx          <= '0;
      dy          <= '0;
      btn_left    <= 1'b0;
      btn_right   <= 1'b0;
      mouse_valid <= 1'b0;
    end
    else
    begin
      mouse_valid <= packet_strobe;
      if (packet_strobe)
      begin
        dx        <= {packet.report.x_sign, packet.report.x_data};
        dy        <= {packet.report.y_sign, packet.report.y_data};
        btn_left  <= packet.report.left;
        btn_right <= packet.report.right;
        mx        <= step(mx, mag_x, !packet.report.x_sign, limit_x);
        // mouse up is positive Y but moves the cursor toward row zero
        my        <= step(my, mag_y, packet.report.y_sign, limit_y);
      end
    end
  end

endmodule

//--- logic/ps2_mouse.sv
// ----------------------------------------
// PS/2 mouse host top level
// connect both lines to pins with pullups and read the cursor outputs
// ----------------------------------------
`timescale 1ns/100ps

module ps2_mouse #(
  parameter int watchdog_value = 26000,
  parameter int watchdog_bits  = 15,
  parameter int debounce_value = 246,
  parameter int debounce_bits  = 8,
  parameter int max_x          = 1023,
  parameter int max_y          = 767
) (
  input  logic              clk,
  input  logic              reset,
  inout  wire               ps2_clk,
  inout  wire               ps2_data,
  output mouse_pkg::coord_t mx,
  output mouse_pkg::coord_t my,
  output mouse_pkg::incr_t  dx,
  output mouse_pkg::incr_t  dy,
  output logic              btn_left,
  output logic              btn_right,
  output logic              mouse_valid,
  output logic              error_no_ack
);

  logic             clean_clk;
  logic             clk_rise;
  logic             clk_fall;
  logic [5:0]       bit_count;
  logic             watchdog_done;
  ps2_pkg::packet_u packet;
  logic             packet_good;
  logic             packet_strobe;

  // clock line edges drive everything else
  ps2_clk_tracker #(
    .debounce_value (debounce_value),
    .debounce_bits  (debounce_bits)
  ) i_clk_tracker (
    .clk       (clk),
    .reset     (reset),
    .ps2_clk   (ps2_clk),
    .clean_clk (clean_clk),
    .clk_rise  (clk_rise),
    .clk_fall  (clk_fall)
  );

  ps2_receiver #(
    .watchdog_value (watchdog_value),
    .watchdog_bits  (watchdog_bits)
  ) i_receiver (
    .clk           (clk),
    .reset         (reset),
    .ps2_data      (ps2_data),
    .clk_rise      (clk_rise),
    .clk_fall      (clk_fall),
    .bit_count     (bit_count),
    .watchdog_done (watchdog_done),
    .packet        (packet),
    .packet_good   (packet_good)
  );

  ps2_link_control i_link_control (
    .clk           (clk),
    .reset         (reset),
    .ps2_clk       (ps2_clk),
    .ps2_data      (ps2_data),
    .clean_clk     (clean_clk),
    .clk_rise      (clk_rise),
    .clk_fall      (clk_fall),
    .bit_count     (bit_count),
    .watchdog_done (watchdog_done),
    .packet_good   (packet_good),
    .packet_strobe (packet_strobe),
    .error_no_ack  (error_no_ack)
  );

  mouse_tracker #(
    .max_x (max_x),
    .max_y (max_y)
  ) i_mouse_tracker (
    .clk           (clk),
    .reset         (reset),
    .packet_strobe (packet_strobe),
    .packet        (packet),
    .mx            (mx),
    .my            (my),
    .dx            (dx),
    .dy            (dy),
    .btn_left      (btn_left),
    .btn_right     (btn_right),
    .mouse_valid   (mouse_valid)
  );

endmodule

//--- tb/ps2_mouse_model.sv
// ----------------------------------------
// behavioral PS/2 mouse for the host testbench
// answers host commands and sends report bits when a task is called
// ----------------------------------------
`timescale 1ns/100ps

module ps2_mouse_model (
  input  logic clk,
  inout  wire  ps2_clk,
  inout  wire  ps2_data
);

  localparam int half_period = 20;
  localparam int byte_gap    = 60;
  localparam int packet_gap  = 400;

  logic clk_low;
  logic data_low;

  // open drain, the testbench pullups give the high level
  assign ps2_clk  = clk_low  ? 1'b0 : 1'bz;
  assign ps2_data = data_low ? 1'b0 : 1'bz;

  initial
  begin
    clk_low  = 1'b0;
    data_low = 1'b0;
  end

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  // one full clock period on the line, low phase first
  task automatic pulse_clock();
    clk_low <= 1'b1;
    wait_cycles(half_period);
    clk_low <= 1'b0;
    wait_cycles(half_period);
  endtask

  // shifts bits out LSB first with a gap after every frame
  // a count below 33 leaves the report cut short
  task automatic shift_bits(input logic [32:0] bits, input int count);
    for (int i = 0; i < count; i++)
    begin
      if ((i > 0) && (i % ps2_pkg::frame_bits == 0))
        wait_cycles(byte_gap);
      // data changes only while the clock is high
      data_low <= !bits[i];
      wait_cycles(5);
      pulse_clock();
      if (i % ps2_pkg::frame_bits == ps2_pkg::frame_bits - 1)
        data_low <= 1'b0;
    end
    data_low <= 1'b0;
  endtask

  // a report starts after the quiet time between packets
  task automatic send_bits(input logic [32:0] bits, input int count);
    wait_cycles(packet_gap);
    shift_bits(bits, count);
  endtask

  // waits for a host request and clocks in its frame
  // frame holds start in bit 0 and stop in bit 10, as on the line
  task automatic serve_command(input logic give_ack, output logic [10:0] frame);
    logic [7:0] answer;
    answer = 8'hFA;
    wait (ps2_clk === 1'b0);
    // the host lets the clock go and holds data low as the start bit
    wait ((ps2_clk === 1'b1) && (ps2_data === 1'b0));
    wait_cycles(half_period);
    frame[0] = 1'b0;
    for (int i = 1; i < ps2_pkg::frame_bits; i++)
    begin
      clk_low <= 1'b1;
      wait_cycles(half_period / 2);
      // sample in the middle of the low phase
      frame[i] = ps2_data;
      wait_cycles(half_period / 2);
      clk_low <= 1'b0;
      wait_cycles(half_period);
    end
    // ack slot, data low through the low phase of the eleventh clock
    if (give_ack)
      data_low <= 1'b1;
    pulse_clock();
    data_low <= 1'b0;
    // the answer follows after one byte gap, well inside the host watchdog
    if (give_ack)
    begin
      wait_cycles(byte_gap);
      shift_bits({22'd0, 1'b1, ~^answer, answer, 1'b0}, ps2_pkg::frame_bits);
    end
  endtask

endmodule

//--- tb/tb_ps2_mouse.sv
// ----------------------------------------
// testbench for the PS/2 mouse host with a behavioral mouse
// random reports are checked against a cursor model kept here
// ----------------------------------------
`timescale 1ns/100ps

module tb_ps2_mouse;

  localparam int max_x         = 1023;
  localparam int max_y         = 767;
  localparam int packet_cycles = 2500;
  localparam int total_packets = 80;

  logic clk;
  logic reset;
  wire  ps2_clk;
  wire  ps2_data;
  mouse_pkg::coord_t mx;
  mouse_pkg::coord_t my;
  mouse_pkg::incr_t  dx;
  mouse_pkg::incr_t  dy;
  logic btn_left;
  logic btn_right;
  logic mouse_valid;
  logic error_no_ack;

  logic [15:0] lfsr_state;
  int errors;
  int tests_run;
  int ref_x;
  int ref_y;

  pullup (ps2_clk);
  pullup (ps2_data);

  ps2_mouse #(
    .watchdog_value (200),
    .debounce_value (4),
    .max_x          (max_x),
    .max_y          (max_y)
  ) i_ps2_mouse (
    .clk          (clk),
    .reset        (reset),
    .ps2_clk      (ps2_clk),
    .ps2_data     (ps2_data),
    .mx           (mx),
    .my           (my),
    .dx           (dx),
    .dy           (dy),
    .btn_left     (btn_left),
    .btn_right    (btn_right),
    .mouse_valid  (mouse_valid),
    .error_no_ack (error_no_ack)
  );

  ps2_mouse_model i_ps2_mouse_model (
    .clk      (clk),
    .ps2_clk  (ps2_clk),
    .ps2_data (ps2_data)
  );

  initial
  begin
    clk        = 1'b0;
    reset      = 1'b1;
    lfsr_state = 16'd43;
    errors     = 0;
    tests_run  = 0;
  end

  always #20 clk = ~clk;

  // run limit from the packet count and the time one packet takes
  initial
  begin
    #(total_packets * packet_cycles * 40);
    $display("timeout, the run did not finish in time");
    $display("Simulation FAILED");
    $finish;
  end

  // ----------------------------------------
  // random bits and the cursor model
  // ----------------------------------------

  // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic logic [7:0] random_byte();
    logic [7:0] value;
    for (int i = 0; i < 8; i++)
      value[i] = lfsr_bit();
    return value;
  endfunction

  function automatic int clamp(input int value, input int limit);
    if (value < 0)
      return 0;
    if (value > limit)
      return limit;
    return value;
  endfunction

  // frame as it goes on the line: start, data, odd parity, stop
  function automatic logic [10:0] line_frame(input logic [7:0] data);
    return {1'b1, ~^data, data, 1'b0};
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("FAILED %s expected %h got %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before)
      $display("test %s passed", name);
    else
      $display("test %s failed with %0d errors", name, errors - errors_before);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    reset <= 1'b1;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    ref_x = 500;
    ref_y = 340;
  endtask

  // outputs are read at the falling edge, away from the DUT updates
  task automatic wait_valid(input int limit, output logic seen);
    seen = 1'b0;
    for (int i = 0; (i < limit) && !seen; i++)
    begin
      @(negedge clk);
      if (mouse_valid)
        seen = 1'b1;
    end
  endtask

  task automatic command_check(input logic give_ack);
    logic [10:0] frame;
    i_ps2_mouse_model.serve_command(give_ack, frame);
    check_value("command data", 32'hF4, frame[8:1]);
    check_value("command parity", ~^8'hF4, frame[9]);
    check_value("command stop", 32'h1, frame[10]);
  endtask

  // sends one report and checks the pulse and outputs that follow
  task automatic run_report(input logic left, input logic right, input logic xs,
                            input logic [7:0] xd, input logic ys, input logic [7:0] yd);
    logic [7:0]  flags;
    logic [32:0] bits;
    logic        seen;
    flags = {2'b00, ys, xs, 1'b1, 1'b0, right, left};
    bits  = {line_frame(yd), line_frame(xd), line_frame(flags)};
    i_ps2_mouse_model.send_bits(bits, 33);
    wait_valid(600, seen);
    if (!seen)
    begin
      $display("no mouse_valid pulse after a good report");
      errors++;
    end
    else
    begin
      ref_x = clamp(ref_x + (xs ? int'(xd) - 256 : int'(xd)), max_x);
      // Y up from the mouse is toward row zero
      ref_y = clamp(ref_y - (ys ? int'(yd) - 256 : int'(yd)), max_y);
      check_value("dx", {xs, xd}, dx[8:0]);
      check_value("dy", {ys, yd}, dy[8:0]);
      check_value("btn_left", left, btn_left);
      check_value("btn_right", right, btn_right);
      check_value("mx", ref_x, mx);
      check_value("my", ref_y, my);
      // the valid pulse lasts a single cycle
      @(negedge clk);
      check_value("mouse_valid", 0, mouse_valid);
    end
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------

  initial
  begin
    int          start;
    logic [32:0] bits;
    logic        seen;
    logic [7:0]  xd;
    logic [7:0]  yd;
    int          pos;

    // reset values and the first enable command
    start = errors;
    apply_reset();
    @(negedge clk);
    check_value("mx", 500, mx);
    check_value("my", 340, my);
    check_value("dx", 0, dx);
    check_value("dy", 0, dy);
    check_value("btn_left", 0, btn_left);
    check_value("btn_right", 0, btn_right);
    check_value("mouse_valid", 0, mouse_valid);
    check_value("error_no_ack", 0, error_no_ack);
    command_check(1'b1);
    end_test("reset and enable", start);

    start = errors;
    for (int n = 0; n < 20; n++)
      run_report(lfsr_bit(), lfsr_bit(), lfsr_bit(), random_byte(), lfsr_bit(),
                 random_byte());
    end_test("random reports", start);

    // many full-scale moves push the cursor into every clamp
    start = errors;
    for (int n = 0; n < 30; n++)
    begin
      xd = lfsr_bit() ? (lfsr_bit() ? 8'hFF : 8'h00) : random_byte();
      yd = lfsr_bit() ? (lfsr_bit() ? 8'hFF : 8'h00) : random_byte();
      run_report(lfsr_bit(), lfsr_bit(), lfsr_bit(), xd, lfsr_bit(), yd);
    end
    // five full moves reach the right and bottom edges from anywhere
    for (int n = 0; n < 5; n++)
      run_report(1'b0, 1'b0, 1'b0, 8'hFF, 1'b1, 8'h00);
    check_value("mx", max_x, mx);
    check_value("my", max_y, my);
    // and five more the opposite way reach row and column zero
    for (int n = 0; n < 5; n++)
      run_report(1'b0, 1'b0, 1'b1, 8'h00, 1'b0, 8'hFF);
    check_value("mx", 0, mx);
    check_value("my", 0, my);
    end_test("long clamped sequence", start);

    // one parity or stop bit flipped in a random frame
    start = errors;
    for (int n = 0; n < 3; n++)
    begin
      bits = {line_frame(random_byte()), line_frame(random_byte()),
              line_frame({4'd0, 1'b1, 1'b0, 2'd0})};
      pos  = (n * 11) + (lfsr_bit() ? 9 : 10);
      bits[pos] = ~bits[pos];
      i_ps2_mouse_model.send_bits(bits, 33);
      wait_valid(600, seen);
      if (seen)
      begin
        $display("a corrupted report produced a mouse_valid pulse");
        errors++;
      end
      check_value("mx", ref_x, mx);
      check_value("my", ref_y, my);
    end
    end_test("corrupted reports", start);

    // a cut report makes the host enable streaming again
    start = errors;
    bits = {line_frame(8'h10), line_frame(8'h20), line_frame(8'h08)};
    i_ps2_mouse_model.send_bits(bits, 15);
    command_check(1'b1);
    run_report(lfsr_bit(), lfsr_bit(), lfsr_bit(), random_byte(), lfsr_bit(),
               random_byte());
    end_test("truncated report", start);

    start = errors;
    apply_reset();
    i_ps2_mouse_model.serve_command(1'b0, bits[10:0]);
    repeat (50) @(posedge clk);
    @(negedge clk);
    check_value("error_no_ack", 1, error_no_ack);
    repeat (500) @(posedge clk);
    @(negedge clk);
    check_value("error_no_ack", 1, error_no_ack);
    apply_reset();
    command_check(1'b1);
    repeat (500) @(posedge clk);
    @(negedge clk);
    check_value("error_no_ack", 0, error_no_ack);
    end_test("missing ack", start);

    $display("tests run %0d, errors %0d", tests_run, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

//--- list.f
common/ps2_pkg.sv
common/mouse_pkg.sv
ps2/ps2_clk_tracker.sv
ps2/ps2_receiver.sv
ps2/ps2_link_control.sv
logic/mouse_tracker.sv
logic/ps2_mouse.sv
tb/ps2_mouse_model.sv
tb/tb_ps2_mouse.sv
